/* list.f */
design/dummy_pkg.sv
design/lfsr_bank.sv
design/dummy_decode.sv
design/dummy_execute.sv
design/dummy_result.sv
design/dummy_insert_top.sv
verification/dummy_insert_tb.sv

/* verification/dummy_insert_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy insertion testbench
// Random fetch stream, reference model and clocked checks
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module dummy_insert_tb;
  import dummy_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int DISABLED_N  = 40;
  localparam int SEED_N      = 40;
  localparam int BAND_N      = 200;
  localparam int ACCEPT_WAIT = 1;
  // At most three cycles per instruction, plus reset, band switches and drain
  localparam int WATCHDOG_CYCLES = 3 * (DISABLED_N + 2 * SEED_N + 5 * BAND_N) + 200;

  logic        clk_i;
  logic        rst_ni;
  logic        instr_valid_i;
  fetch_pkt_t  fetch_i;
  logic        fetch_ready_o;
  logic        rnddummy_en_i;
  dummy_freq_t dummy_freq_i;
  seed_wr_t    seed_wr_i;
  inhibit_t    count_inhibit_i;
  logic        issue_valid_o;
  issue_pkt_t  issue_o;
  logic        retire_valid_o;
  retire_pkt_t retire_o;
  cnt_t        mcycle_o;
  cnt_t        minstret_o;

  word_t       rng_state = 32'd37;
  retire_pkt_t expected_q [$];
  word_t       lfsr_m [3];
  word_t       pend_a;
  word_t       pend_b;
  int          spacing_m;
  cnt_t        mcycle_m;
  cnt_t        minstret_m;
  logic        prev_accept;
  logic        prev_step;
  logic        prev_issue_valid;
  logic        prev_issue_dummy;

  dummy_insert_top dummy_insert_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    fail_run($sformatf("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp));
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("Watchdog expired before the test sequence finished");
  end

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output word_t v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // Right-shift Galois step with the package polynomial
  function automatic word_t lfsr_step(input word_t v);
    return (v >> 1) ^ (v[0] ? LFSR_TAPS : '0);
  endfunction

  function automatic word_t lfsr_default(input int i);
    case (i)
      0: return LFSR0_DEFAULT;
      1: return LFSR1_DEFAULT;
      default: return LFSR2_DEFAULT;
    endcase
  endfunction

  function automatic int band_max(input dummy_freq_t f);
    if (f >= 8) return 64;
    else if (f >= 4) return 32;
    else if (f >= 2) return 16;
    else if (f == 1) return 8;
    else return 4;
  endfunction

  function automatic dummy_freq_t pick_freq(input int band, input word_t r);
    case (band)
      0: return 4'd0;
      1: return 4'd1;
      2: return {3'b001, r[0]};
      3: return {2'b01, r[1:0]};
      default: return {1'b1, r[2:0]};
    endcase
  endfunction

  // Kind in r[1:0], register fields and branch offset from the rest
  function automatic word_t build_instr(input word_t r);
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    rd  = r[6:2];
    rs1 = r[11:7];
    rs2 = r[16:12];
    case (r[1:0])
      2'd0: return {FUNCT7_ADD, rs2, rs1, FUNCT3_ADD, rd, OPCODE_OP};
      2'd1: return {FUNCT7_AND, rs2, rs1, FUNCT3_AND, rd, OPCODE_OP};
      2'd2: return {FUNCT7_MUL, rs2, rs1, FUNCT3_MUL, rd, OPCODE_OP};
      default: return {r[23:17], rs2, rs1, FUNCT3_BLTU, r[28:24], OPCODE_BRANCH};
    endcase
  endfunction

  function automatic retire_pkt_t expected_retire(input logic [1:0] kind, input word_t instr,
                                                  input word_t a, input word_t b);
    retire_pkt_t e;
    e.instr        = instr;
    e.result       = '0;
    e.branch_taken = 1'b0;
    e.dummy        = 1'b0;
    case (kind)
      2'd0: e.result = a + b;
      2'd1: e.result = a & b;
      2'd2: e.result = a * b;
      default: e.branch_taken = a < b;
    endcase
    return e;
  endfunction

  task automatic check_dummy_encoding(input word_t instr);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    opcode = instr[6:0];
    f3     = instr[14:12];
    f7     = instr[31:25];
    if (opcode == OPCODE_OP) begin
      assert (instr[11:7] == REG_X0) else report_mismatch("dummy rd", instr[11:7], REG_X0);
      assert ((f7 == FUNCT7_ADD && f3 == FUNCT3_ADD) || (f7 == FUNCT7_AND && f3 == FUNCT3_AND) ||
              (f7 == FUNCT7_MUL && f3 == FUNCT3_MUL))
        else fail_run("Dummy ALU instruction is not ADD, AND or MUL");
    end else if (opcode == OPCODE_BRANCH) begin
      assert (f3 == FUNCT3_BLTU) else report_mismatch("dummy branch funct3", f3, FUNCT3_BLTU);
      assert ({f7, instr[11:7]} == '0)
        else report_mismatch("dummy branch offset", {f7, instr[11:7]}, 0);
    end else begin
      fail_run($sformatf("Dummy has unexpected opcode %b", opcode));
    end
  endtask

  // Model and checks, sampled on the rising edge before any update
  always @(posedge clk_i) begin : scoreboard
    logic        accept;
    logic        step;
    word_t       nxt;
    retire_pkt_t exp;
    if (!rst_ni) begin
      for (int i = 0; i < 3; i++) begin
        lfsr_m[i] = lfsr_default(i);
      end
      spacing_m        = 0;
      mcycle_m         = '0;
      minstret_m       = '0;
      prev_accept      = 1'b0;
      prev_step        = 1'b0;
      prev_issue_valid = 1'b0;
      prev_issue_dummy = 1'b0;
    end else begin
      accept = instr_valid_i && fetch_ready_o;
      step   = !fetch_ready_o;
      if (!rnddummy_en_i) begin
        assert (fetch_ready_o) else fail_run("fetch_ready_o low with dummy insertion disabled");
      end
      assert (issue_valid_o == (prev_accept || prev_step))
        else report_mismatch("issue_valid_o", issue_valid_o, prev_accept || prev_step);
      if (issue_valid_o) begin
        assert (issue_o.dummy == prev_step)
          else report_mismatch("issue_o.dummy", issue_o.dummy, prev_step);
        if (issue_o.dummy) begin
          check_dummy_encoding(issue_o.instr);
          assert (issue_o.op_a == pend_a) else report_mismatch("issue_o.op_a", issue_o.op_a, pend_a);
          assert (issue_o.op_b == pend_b) else report_mismatch("issue_o.op_b", issue_o.op_b, pend_b);
        end
      end
      assert (retire_valid_o == prev_issue_valid)
        else report_mismatch("retire_valid_o", retire_valid_o, prev_issue_valid);
      if (retire_valid_o) begin
        assert (retire_o.dummy == prev_issue_dummy)
          else report_mismatch("retire_o.dummy", retire_o.dummy, prev_issue_dummy);
        if (!retire_o.dummy) begin
          if (expected_q.size() == 0) begin
            fail_run("Normal instruction retired with none outstanding");
          end else begin
            exp = expected_q.pop_front();
            assert (retire_o.instr == exp.instr)
              else report_mismatch("retire_o.instr", retire_o.instr, exp.instr);
            assert (retire_o.result == exp.result)
              else report_mismatch("retire_o.result", retire_o.result, exp.result);
            assert (retire_o.branch_taken == exp.branch_taken)
              else report_mismatch("retire_o.branch_taken", retire_o.branch_taken,
                                   exp.branch_taken);
          end
        end
      end
      assert (mcycle_o == mcycle_m) else report_mismatch("mcycle_o", mcycle_o, mcycle_m);
      assert (minstret_o == minstret_m) else report_mismatch("minstret_o", minstret_o, minstret_m);
      // Normal instructions since the last dummy stay within the band
      if (step || !rnddummy_en_i) begin
        spacing_m = 0;
      end else if (accept) begin
        assert (spacing_m < band_max(dummy_freq_i))
          else fail_run($sformatf("More than %0d normal instructions between two dummies",
                                  band_max(dummy_freq_i)));
        spacing_m++;
      end
      if (!count_inhibit_i[CNT_MCYCLE]) begin
        mcycle_m = mcycle_m + 1;
      end
      if (retire_valid_o && !retire_o.dummy && !count_inhibit_i[CNT_MINSTRET]) begin
        minstret_m = minstret_m + 1;
      end
      // Dummy operands come from the state before this edge
      if (step) begin
        pend_a = lfsr_m[1];
        pend_b = lfsr_m[2];
      end
      for (int i = 0; i < 3; i++) begin
        if (seed_wr_i.we && (int'(seed_wr_i.sel) == i)) begin
          nxt = seed_wr_i.data;
        end else if (step) begin
          nxt = lfsr_step(lfsr_m[i]);
        end else begin
          nxt = lfsr_m[i];
        end
        lfsr_m[i] = (nxt == '0) ? lfsr_default(i) : nxt;
      end
      prev_accept      = accept;
      prev_step        = step;
      prev_issue_valid = issue_valid_o;
      prev_issue_dummy = issue_o.dummy;
    end
  end

  task automatic send_instr();
    word_t      r;
    word_t      a;
    word_t      b;
    word_t      g;
    fetch_pkt_t pkt;
    int         waited;
    draw(r);
    draw(a);
    draw(b);
    // Equal operands now and then for the BLTU boundary
    if (r[31:29] == 3'd0) begin
      b = a;
    end
    pkt.instr = build_instr(r);
    pkt.op_a  = a;
    pkt.op_b  = b;
    instr_valid_i <= 1'b1;
    fetch_i       <= pkt;
    waited = 0;
    @(posedge clk_i);
    while (!fetch_ready_o) begin
      waited++;
      if (waited > ACCEPT_WAIT) begin
        fail_run("Instruction held back by fetch_ready_o for too long");
      end else begin
        @(posedge clk_i);
      end
    end
    expected_q.push_back(expected_retire(r[1:0], pkt.instr, a, b));
    draw(g);
    if (g[3:0] == 4'd0) begin
      count_inhibit_i <= g[5:4];
    end
    if (g[7:6] == 2'd0) begin
      instr_valid_i <= 1'b0;
      @(posedge clk_i);
    end
  endtask

  task automatic run_normals(input int n);
    repeat (n) begin
      send_instr();
    end
    instr_valid_i   <= 1'b0;
    count_inhibit_i <= '0;
    @(posedge clk_i);
  endtask

  task automatic write_seed(input logic [1:0] sel, input word_t data);
    seed_wr_i <= {1'b1, sel, data};
    @(posedge clk_i);
    seed_wr_i <= '0;
  endtask

  task automatic set_feature(input logic en, input dummy_freq_t freq);
    rnddummy_en_i <= en;
    dummy_freq_i  <= freq;
    @(posedge clk_i);
  endtask

  initial begin
    word_t r;
    rst_ni          = 1'b0;
    instr_valid_i   = 1'b0;
    fetch_i         = '0;
    rnddummy_en_i   = 1'b0;
    dummy_freq_i    = '0;
    seed_wr_i       = '0;
    count_inhibit_i = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Feature off
    run_normals(DISABLED_N);

    // Nonzero seeds become the first dummy operands
    draw(r);
    write_seed(2'd1, r | 32'd1);
    draw(r);
    write_seed(2'd2, r | 32'd1);
    draw(r);
    write_seed(2'd0, r | 32'd1);
    set_feature(1'b1, 4'd0);
    run_normals(SEED_N);

    // A zero seed falls back to the default
    set_feature(1'b0, 4'd0);
    write_seed(2'd1, '0);
    set_feature(1'b1, 4'd0);
    run_normals(SEED_N);

    for (int band = 0; band < 5; band++) begin
      draw(r);
      set_feature(1'b0, pick_freq(band, r));
      set_feature(1'b1, pick_freq(band, r));
      run_normals(BAND_N);
    end

    set_feature(1'b0, 4'd0);
    repeat (4) @(posedge clk_i);
    if (expected_q.size() != 0) begin
      fail_run($sformatf("%0d normal instructions never retired", expected_q.size()));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

/* design/dummy_insert_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy insertion top
// Decode, execute and counters of the dummy instruction path
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module dummy_insert_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   instr_valid_i,
  input  dummy_pkg::fetch_pkt_t  fetch_i,
  output logic                   fetch_ready_o,
  input  logic                   rnddummy_en_i,
  input  dummy_pkg::dummy_freq_t dummy_freq_i,
  input  dummy_pkg::seed_wr_t    seed_wr_i,
  input  dummy_pkg::inhibit_t    count_inhibit_i,
  output logic                   issue_valid_o,
  output dummy_pkg::issue_pkt_t  issue_o,
  output logic                   retire_valid_o,
  output dummy_pkg::retire_pkt_t retire_o,
  output dummy_pkg::cnt_t        mcycle_o,
  output dummy_pkg::cnt_t        minstret_o
);

  dummy_decode dummy_decode_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .fetch_i       (fetch_i),
    .fetch_ready_o (fetch_ready_o),
    .rnddummy_en_i (rnddummy_en_i),
    .dummy_freq_i  (dummy_freq_i),
    .seed_wr_i     (seed_wr_i),
    .issue_valid_o (issue_valid_o),
    .issue_o       (issue_o)
  );

  // Issue stage feeds execute directly
  dummy_execute dummy_execute_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid_o),
    .issue_i        (issue_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  dummy_result dummy_result_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .retire_valid_i  (retire_valid_o),
    .dummy_i         (retire_o.dummy),
    .count_inhibit_i (count_inhibit_i),
    .mcycle_o        (mcycle_o),
    .minstret_o      (minstret_o)
  );

endmodule

/* design/dummy_result.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Performance counters
// mcycle and minstret, dummies never retire
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module dummy_result (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                retire_valid_i,
  input  logic                dummy_i,
  input  dummy_pkg::inhibit_t count_inhibit_i,
  output dummy_pkg::cnt_t     mcycle_o,
  output dummy_pkg::cnt_t     minstret_o
);
  import dummy_pkg::*;

  logic instr_retired;

  assign instr_retired = retire_valid_i && !dummy_i;

  // Counts every cycle, dummy cycles included
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mcycle_o <= '0;
    end else if (!count_inhibit_i[CNT_MCYCLE]) begin
      mcycle_o <= mcycle_o + cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      minstret_o <= '0;
    end else if (instr_retired && !count_inhibit_i[CNT_MINSTRET]) begin
      minstret_o <= minstret_o + cnt_t'(1);
    end
  end

endmodule

/* design/dummy_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy execute
// One-stage ALU for ADD, AND, MUL and BLTU with a retire register
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module dummy_execute (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   issue_valid_i,
  input  dummy_pkg::issue_pkt_t  issue_i,
  output logic                   retire_valid_o,
  output dummy_pkg::retire_pkt_t retire_o
);
  import dummy_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  retire_pkt_t retire_d;

  assign opcode = issue_i.instr[6:0];
  assign funct3 = issue_i.instr[14:12];
  assign funct7 = issue_i.instr[31:25];

  always_comb begin
    retire_d.instr        = issue_i.instr;
    retire_d.result       = '0;
    retire_d.branch_taken = 1'b0;
    retire_d.dummy        = issue_i.dummy;
    if (opcode == OPCODE_OP) begin
      // MUL first since it shares funct3 with ADD
      if ((funct7 == FUNCT7_MUL) && (funct3 == FUNCT3_MUL)) begin
        retire_d.result = issue_i.op_a * issue_i.op_b;
      end else if ((funct7 == FUNCT7_AND) && (funct3 == FUNCT3_AND)) begin
        retire_d.result = issue_i.op_a & issue_i.op_b;
      end else if ((funct7 == FUNCT7_ADD) && (funct3 == FUNCT3_ADD)) begin
        retire_d.result = issue_i.op_a + issue_i.op_b;
      end
    end else if ((opcode == OPCODE_BRANCH) && (funct3 == FUNCT3_BLTU)) begin
      // Unsigned compare, no destination value
      retire_d.branch_taken = issue_i.op_a < issue_i.op_b;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      retire_o <= retire_d;
    end
  end

endmodule

/* design/dummy_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy decode
// Spaces dummies randomly between fetched instructions and issues both
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module dummy_decode (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   instr_valid_i,
  input  dummy_pkg::fetch_pkt_t  fetch_i,
  output logic                   fetch_ready_o,
  input  logic                   rnddummy_en_i,
  input  dummy_pkg::dummy_freq_t dummy_freq_i,
  input  dummy_pkg::seed_wr_t    seed_wr_i,
  output logic                   issue_valid_o,
  output dummy_pkg::issue_pkt_t  issue_o
);
  import dummy_pkg::*;

  lfsr_state_t lfsr;
  logic        step;
  logic [6:0]  spacing_q;
  logic [5:0]  band_mask;
  logic [6:0]  limit;
  logic        insert_dummy;
  logic        accept;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       dummy_instr;
  issue_pkt_t  issue_d;

  lfsr_bank lfsr_bank_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .seed_wr_i (seed_wr_i),
    .step_i    (step),
    .state_o   (lfsr)
  );

  // Band maximum minus one, used as a mask on LFSR0
  always_comb begin
    if (dummy_freq_i[3]) begin
      band_mask = 6'd63;
    end else if (dummy_freq_i[2]) begin
      band_mask = 6'd31;
    end else if (dummy_freq_i[1]) begin
      band_mask = 6'd15;
    end else if (dummy_freq_i[0]) begin
      band_mask = 6'd7;
    end else begin
      band_mask = 6'd3;
    end
  end

  // Limit lies in 1 to band maximum
  assign limit = {1'b0, lfsr.lfsr0[5:0] & band_mask} + 7'd1;

  assign insert_dummy  = rnddummy_en_i && (spacing_q >= limit);
  assign fetch_ready_o = !insert_dummy;
  assign accept        = instr_valid_i && fetch_ready_o;
  // Each dummy moves all LFSRs on, which also draws the next limit
  assign step          = insert_dummy;

  assign rs1 = lfsr.lfsr0[12:8];
  assign rs2 = lfsr.lfsr0[17:13];

  // rd is x0 for ALU dummies, BLTU falls through with a zero offset
  always_comb begin
    case (lfsr.lfsr0[7:6])
      2'd0: dummy_instr = {FUNCT7_ADD, rs2, rs1, FUNCT3_ADD, REG_X0, OPCODE_OP};
      2'd1: dummy_instr = {FUNCT7_AND, rs2, rs1, FUNCT3_AND, REG_X0, OPCODE_OP};
      2'd2: dummy_instr = {FUNCT7_MUL, rs2, rs1, FUNCT3_MUL, REG_X0, OPCODE_OP};
      default: dummy_instr = {7'b0, rs2, rs1, FUNCT3_BLTU, 5'b0, OPCODE_BRANCH};
    endcase
  end

  always_comb begin
    if (insert_dummy) begin
      issue_d.instr = dummy_instr;
      issue_d.op_a  = lfsr.lfsr1;
      issue_d.op_b  = lfsr.lfsr2;
      issue_d.dummy = 1'b1;
    end else begin
      issue_d.instr = fetch_i.instr;
      issue_d.op_a  = fetch_i.op_a;
      issue_d.op_b  = fetch_i.op_b;
      issue_d.dummy = 1'b0;
    end
  end

  // Normal instructions since the last dummy
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      spacing_q <= '0;
    end else if (insert_dummy || !rnddummy_en_i) begin
      spacing_q <= '0;
    end else if (accept) begin
      spacing_q <= spacing_q + 7'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= insert_dummy || accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (insert_dummy || accept) begin
      issue_o <= issue_d;
    end
  end

endmodule

/* design/lfsr_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~
// LFSR bank
// Three seedable Galois LFSRs that reload their default on lockup
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module lfsr_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  dummy_pkg::seed_wr_t    seed_wr_i,
  input  logic                   step_i,
  output dummy_pkg::lfsr_state_t state_o
);
  import dummy_pkg::*;

  word_t lfsr_q [3];
  word_t lfsr_d [3];

  // One Galois step, shifting towards bit 0
  function automatic word_t galois_step(input word_t val);
    word_t shifted;
    shifted = val >> 1;
    if (val[0]) begin
      shifted = shifted ^ LFSR_TAPS;
    end
    return shifted;
  endfunction

  // Reset and lockup reload value of each LFSR
  function automatic word_t lfsr_default(input int idx);
    case (idx)
      0:       return LFSR0_DEFAULT;
      1:       return LFSR1_DEFAULT;
      default: return LFSR2_DEFAULT;
    endcase
  endfunction

  // Seed write wins over a step, and a zero result reloads the default
  always_comb begin
    word_t nxt;
    for (int i = 0; i < 3; i++) begin
      if (seed_wr_i.we && (seed_wr_i.sel == 2'(i))) begin
        nxt = seed_wr_i.data;
      end else if (step_i) begin
        nxt = galois_step(lfsr_q[i]);
      end else begin
        nxt = lfsr_q[i];
      end
      lfsr_d[i] = (nxt == '0) ? lfsr_default(i) : nxt;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 3; i++) begin
      if (!rst_ni) begin
        lfsr_q[i] <= lfsr_default(i);
      end else begin
        lfsr_q[i] <= lfsr_d[i];
      end
    end
  end

  assign state_o.lfsr0 = lfsr_q[0];
  assign state_o.lfsr1 = lfsr_q[1];
  assign state_o.lfsr2 = lfsr_q[2];

endmodule

/* design/dummy_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy instruction package
// Widths, RV32 encodings, LFSR defaults and the packet structs
// ~~~~~~~~~~~~~~~~~~~~

package dummy_pkg;

  localparam int XLEN  = 32;
  localparam int CNT_W = 64;

  // Major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  // Minor opcodes, MUL shares funct3 with ADD
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_MUL  = 3'b000;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;

  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
  localparam logic [6:0] FUNCT7_AND = 7'b0000000;
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

  localparam logic [4:0] REG_X0 = 5'b00000;

  // Reset and lockup reload values, never zero
  localparam logic [XLEN-1:0] LFSR0_DEFAULT = 32'h3A5C_91E7;
  localparam logic [XLEN-1:0] LFSR1_DEFAULT = 32'h5D2B_C3F1;
  localparam logic [XLEN-1:0] LFSR2_DEFAULT = 32'hB4E1_7A09;

  // x^32 + x^22 + x^2 + x + 1 in right-shift Galois form
  localparam logic [XLEN-1:0] LFSR_TAPS = 32'h8020_0003;

  // Bit positions in the inhibit vector
  localparam int CNT_MCYCLE   = 0;
  localparam int CNT_MINSTRET = 1;

  typedef logic [XLEN-1:0]  word_t;
  typedef logic [4:0]       reg_idx_t;
  typedef logic [3:0]       dummy_freq_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [1:0]       inhibit_t;

  typedef struct packed {
    word_t instr;
    word_t op_a;
    word_t op_b;
  } fetch_pkt_t;

  typedef struct packed {
    logic       we;
    logic [1:0] sel;
    word_t      data;
  } seed_wr_t;

  typedef struct packed {
    word_t instr;
    word_t op_a;
    word_t op_b;
    logic  dummy;
  } issue_pkt_t;

  typedef struct packed {
    word_t instr;
    word_t result;
    logic  branch_taken;
    logic  dummy;
  } retire_pkt_t;

  typedef struct packed {
    word_t lfsr0;
    word_t lfsr1;
    word_t lfsr2;
  } lfsr_state_t;

endpackage
